// ==== hdl/data_ram.sv ====
`timescale 1ns/10ps

`include "mem_stage_params.svh"

module data_ram import mem_stage_pkg::*; (
    input  logic       clk,
    input  xlen_t      rd_addr,
    output xlen_t      rd_data,
    input  logic       wr_en,
    input  xlen_t      wr_addr,
    input  xlen_t      wr_data,
    input  byte_mask_t wr_mask
);

    // word storage, contents undefined until written
    xlen_t mem [0:`MEM_WORDS-1];

    // word indices, byte offset bits dropped
    // address bits above the index wrap
    logic [`MEM_IDX_W-1:0] rd_idx;
    logic [`MEM_IDX_W-1:0] wr_idx;

    assign rd_idx = rd_addr[`MEM_IDX_W+2:3];
    assign wr_idx = wr_addr[`MEM_IDX_W+2:3];

    // combinational read port
    assign rd_data = mem[rd_idx];

    // ************************************************************************
    // byte-masked write at the edge
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (wr_en) begin
            // only enabled lanes change
            for (int lane = 0; lane < $bits(byte_mask_t); lane++) begin
                if (wr_mask[lane]) begin
                    mem[wr_idx][lane*8 +: 8] <= wr_data[lane*8 +: 8];
                end
            end
        end
    end

endmodule : data_ram

// ==== hdl/load_extract.sv ====
`timescale 1ns/10ps

`include "mem_stage_params.svh"

module load_extract import mem_stage_pkg::*; (
    input  op_code_t   opcode,
    input  logic [2:0] addr_lo,
    input  xlen_t      rd_data,
    output xlen_t      load_value
);

    // read word moved down so the addressed byte sits in lane 0
    xlen_t       shifted;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] ld_word;

    assign shifted = rd_data >> {addr_lo, 3'b000};

    // ************************************************************************
    // field selection
    // ************************************************************************

    assign ld_byte = shifted[7:0];

    // halfword at offset 7 has no upper byte in this word
    // reads back as zero, same as the store side drops it
    assign ld_half = (addr_lo == 3'd7) ? 16'h0000 : shifted[15:0];

    // words are aligned on bit 2 only
    assign ld_word = addr_lo[2] ? rd_data[63:32] : rd_data[31:0];

    // ************************************************************************
    // sign or zero extension
    // ************************************************************************

    always_comb begin
        case (opcode)
            // signed
            `OP_LB:  load_value = {{56{ld_byte[7]}}, ld_byte};
            `OP_LH:  load_value = {{48{ld_half[15]}}, ld_half};
            `OP_LW:  load_value = {{32{ld_word[31]}}, ld_word};

            // unsigned
            `OP_LBU: load_value = {56'b0, ld_byte};
            `OP_LHU: load_value = {48'b0, ld_half};
            `OP_LWU: load_value = {32'b0, ld_word};

            // whole word as read
            `OP_LD:  load_value = rd_data;

            default: load_value = '0;
        endcase
    end

endmodule : load_extract

// ==== hdl/mem_stage.sv ====
`timescale 1ns/10ps

`include "mem_stage_params.svh"

module mem_stage import mem_stage_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // from execute
    input  logic       valid_ex_mem,
    input  xlen_t      pc_ex_mem,
    input  inst_t      inst_ex_mem,
    input  op_code_t   opcode_ex_mem,
    input  xlen_t      alu_result_ex_mem,
    input  xlen_t      src2_ex_mem,

    // to write-back
    output logic       valid_mem_wb,
    output xlen_t      pc_mem_wb,
    output inst_t      inst_mem_wb,
    output logic       reg_wr_en,
    output reg_idx_t   reg_wr_idx,
    output xlen_t      reg_wr_value,

    // data RAM side
    output xlen_t      rd_addr,
    input  xlen_t      rd_data,
    output logic       wr_en,
    output xlen_t      wr_addr,
    output xlen_t      wr_data,
    output byte_mask_t wr_mask
);

    // stage register
    logic     valid_q;
    xlen_t    pc_q;
    inst_t    inst_q;
    op_code_t opcode_q;
    xlen_t    alu_result_q;
    xlen_t    src2_q;

    // decode results
    logic     is_load;
    logic     is_store;
    logic     wb_en;
    xlen_t    wb_value;
    xlen_t    load_value;

    // ************************************************************************
    // stage register
    // ************************************************************************

    // valid is the only control bit
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_ex_mem;
        end
    end

    // payload follows every cycle
    always_ff @(posedge clk) begin
        pc_q         <= pc_ex_mem;
        inst_q       <= inst_ex_mem;
        opcode_q     <= opcode_ex_mem;
        alu_result_q <= alu_result_ex_mem;
        src2_q       <= src2_ex_mem;
    end

    // ************************************************************************
    // opcode classes
    // ************************************************************************

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (opcode_q)
            `OP_LOAD_CODES:  is_load  = 1'b1;
            `OP_STORE_CODES: is_store = 1'b1;
            default: begin
                is_load  = 1'b0;
                is_store = 1'b0;
            end
        endcase
    end

    // ************************************************************************
    // memory access
    // ************************************************************************

    // address comes straight from the ALU
    assign rd_addr = is_load ? alu_result_q : '0;

    // bubbles never store
    assign wr_en   = valid_q & is_store;
    assign wr_addr = is_store ? alu_result_q : '0;

    store_align u_store_align (
        .opcode  (opcode_q),
        .addr_lo (alu_result_q[2:0]),
        .src2    (src2_q),
        .wr_data (wr_data),
        .wr_mask (wr_mask)
    );

    load_extract u_load_extract (
        .opcode     (opcode_q),
        .addr_lo    (alu_result_q[2:0]),
        .rd_data    (rd_data),
        .load_value (load_value)
    );

    // ************************************************************************
    // write-back selection
    // ************************************************************************

    always_comb begin
        wb_en    = 1'b1;
        wb_value = '0;
        case (opcode_q)
            `OP_LOAD_CODES:       wb_value = load_value;
            `OP_ALU_CODES:        wb_value = alu_result_q;
            // link address
            `OP_JAL, `OP_JALR:    wb_value = pc_q + 64'd4;
            // csr read value rides on src2
            `OP_CSR_A, `OP_CSR_B: wb_value = src2_q;
            // stores and unknown codes write nothing
            default: begin
                wb_en    = 1'b0;
                wb_value = '0;
            end
        endcase
    end

    // gated by valid, bubble gives zero index and value
    assign reg_wr_en    = valid_q & wb_en;
    assign reg_wr_idx   = valid_q ? inst_q[11:7] : '0;
    assign reg_wr_value = valid_q ? wb_value : '0;

    // pass-through to write-back
    assign valid_mem_wb = valid_q;
    assign pc_mem_wb    = pc_q;
    assign inst_mem_wb  = inst_q;

endmodule : mem_stage

// ==== hdl/mem_stage_params.svh ====
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// ************************************************************************
// decoder opcode codes seen by the memory stage
// ************************************************************************

// loads
`define OP_LB       24'd11
`define OP_LH       24'd12
`define OP_LW       24'd13
`define OP_LBU      24'd14
`define OP_LHU      24'd15
`define OP_LWU      24'd41
`define OP_LD       24'd42

// stores
`define OP_SB       24'd16
`define OP_SH       24'd17
`define OP_SW       24'd18
`define OP_SD       24'd43

// link codes, write pc + 4
`define OP_JAL      24'd4
`define OP_JALR     24'h300

// csr reads, value arrives on src2
`define OP_CSR_A    24'd49
`define OP_CSR_B    24'd50

// case-item groups
`define OP_LOAD_CODES  `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_LWU, `OP_LD
`define OP_STORE_CODES `OP_SB, `OP_SH, `OP_SW, `OP_SD

// every other register writer takes the ALU result
`define OP_ALU_CODES \
    24'h4000, 24'h5000, 24'h6000, 24'h7000, 24'h8000, 24'h9000, 24'h10000, \
    24'h12000, 24'h13000, 24'h14000, 24'h15000, 24'h16000, 24'h17000, \
    24'h18000, 24'h19000, 24'h1a000, 24'h1b000, 24'h1d000, 24'h21000, \
    24'h22000, 24'h24000, 24'h25000, 24'h26000, 24'h27000, 24'h28000, \
    24'h29000, 24'h100, 24'h200, 24'h400, 24'h800, 24'hc00, \
    24'd19, 24'd20, 24'd21, 24'd22, 24'd23, 24'd24, 24'd47

// ************************************************************************
// data RAM geometry
// ************************************************************************

// depth in 64-bit words, index taken from address bits above bit 2
`define MEM_WORDS   512
`define MEM_IDX_W   9

`endif

// ==== hdl/mem_stage_pkg.sv ====
// ************************************************************************
// shared types for the memory-access stage and its data RAM
// ************************************************************************

package mem_stage_pkg;

    // one machine word of the RV64 datapath
    // carries pc, ALU result, operands, memory data and write-back value
    typedef logic [63:0] xlen_t;

    // one fetched instruction word
    typedef logic [31:0] inst_t;

    // decoder operation code
    // codes are listed as macros in mem_stage_params.svh
    typedef logic [23:0] op_code_t;

    // byte-lane enables for a 64-bit word
    // bit n enables byte n, i.e. data bits 8n+7 down to 8n
    typedef logic [7:0] byte_mask_t;

    // architectural register index, x0 to x31
    typedef logic [4:0] reg_idx_t;

endpackage : mem_stage_pkg

// ==== hdl/mem_subsys_top.sv ====
`timescale 1ns/10ps

module mem_subsys_top import mem_stage_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    // execute side
    input  logic     valid_ex_mem,
    input  xlen_t    pc_ex_mem,
    input  inst_t    inst_ex_mem,
    input  op_code_t opcode_ex_mem,
    input  xlen_t    alu_result_ex_mem,
    input  xlen_t    src2_ex_mem,

    // write-back side
    output logic     valid_mem_wb,
    output xlen_t    pc_mem_wb,
    output inst_t    inst_mem_wb,
    output logic     reg_wr_en,
    output reg_idx_t reg_wr_idx,
    output xlen_t    reg_wr_value
);

    // stage to RAM
    xlen_t      rd_addr;
    xlen_t      rd_data;
    logic       wr_en;
    xlen_t      wr_addr;
    xlen_t      wr_data;
    byte_mask_t wr_mask;

    // ************************************************************************
    // memory-access stage
    // ************************************************************************

    mem_stage u_mem_stage (
        .clk               (clk),
        .rst               (rst),
        .valid_ex_mem      (valid_ex_mem),
        .pc_ex_mem         (pc_ex_mem),
        .inst_ex_mem       (inst_ex_mem),
        .opcode_ex_mem     (opcode_ex_mem),
        .alu_result_ex_mem (alu_result_ex_mem),
        .src2_ex_mem       (src2_ex_mem),
        .valid_mem_wb      (valid_mem_wb),
        .pc_mem_wb         (pc_mem_wb),
        .inst_mem_wb       (inst_mem_wb),
        .reg_wr_en         (reg_wr_en),
        .reg_wr_idx        (reg_wr_idx),
        .reg_wr_value      (reg_wr_value),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .wr_mask           (wr_mask)
    );

    // data memory, read in the same cycle
    data_ram u_data_ram (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_mask (wr_mask)
    );

endmodule : mem_subsys_top

// ==== hdl/store_align.sv ====
`timescale 1ns/10ps

`include "mem_stage_params.svh"

module store_align import mem_stage_pkg::*; (
    input  op_code_t   opcode,
    input  logic [2:0] addr_lo,
    input  xlen_t      src2,
    output xlen_t      wr_data,
    output byte_mask_t wr_mask
);

    // byte offset turned into a bit offset
    logic [5:0] bit_off;

    assign bit_off = {addr_lo, 3'b000};

    // ************************************************************************
    // lane placement and mask per store width
    // ************************************************************************

    always_comb begin
        // non-store codes leave both zero
        wr_data = '0;
        wr_mask = '0;

        case (opcode)
            // single byte, any offset
            `OP_SB: begin
                wr_data = {56'b0, src2[7:0]} << bit_off;
                wr_mask = 8'h01 << addr_lo;
            end

            // halfword, offset 7 would straddle the word
            `OP_SH: begin
                if (addr_lo != 3'd7) begin
                    wr_data = {48'b0, src2[15:0]} << bit_off;
                    wr_mask = 8'h03 << addr_lo;
                end
            end

            // word, lower or upper half by addr bit 2
            `OP_SW: begin
                if (addr_lo[2]) begin
                    wr_data = {src2[31:0], 32'b0};
                    wr_mask = 8'hf0;
                end else begin
                    wr_data = {32'b0, src2[31:0]};
                    wr_mask = 8'h0f;
                end
            end

            // full doubleword
            `OP_SD: begin
                wr_data = src2;
                wr_mask = 8'hff;
            end

            default: begin
                wr_data = '0;
                wr_mask = '0;
            end
        endcase
    end

endmodule : store_align

// ==== tb.f ====
+incdir+hdl
+incdir+verif
hdl/mem_stage_pkg.sv
hdl/store_align.sv
hdl/load_extract.sv
hdl/data_ram.sv
hdl/mem_stage.sv
hdl/mem_subsys_top.sv
verif/mem_subsys_tb.sv

// ==== verif/mem_model.svh ====
`ifndef MEM_MODEL_SVH
`define MEM_MODEL_SVH

// ************************************************************************
// byte-wide mirror of the data RAM
// ************************************************************************

// one entry per byte, word n holds bytes 8n to 8n+7
logic [7:0] model_bytes [0:`MEM_WORDS*8-1];

// lane 0 of the addressed word, high address bits wrap
function automatic int unsigned word_base(input xlen_t addr);
    return int'(addr[`MEM_IDX_W+2:3]) * 8;
endfunction

// first lane and byte count of an access, count zero means nothing moves
function automatic void access_span(input op_code_t op, input xlen_t addr,
                                    output int unsigned first, output int unsigned count);
    first = addr[2:0];
    count = 0;
    case (op)
        `OP_SB, `OP_LB, `OP_LBU: count = 1;
        // halfword at lane 7 would cross into the next word, dropped
        `OP_SH, `OP_LH, `OP_LHU: count = (addr[2:0] == 3'd7) ? 0 : 2;
        // words sit on bit 2 only
        `OP_SW, `OP_LW, `OP_LWU: begin
            first = addr[2] ? 4 : 0;
            count = 4;
        end
        `OP_SD, `OP_LD: begin
            first = 0;
            count = 8;
        end
        default: count = 0;
    endcase
endfunction

// store in program order, low bytes of data go to the first lane
function automatic void store_to_model(input op_code_t op, input xlen_t addr,
                                       input xlen_t data);
    int unsigned first;
    int unsigned count;
    count = 0;
    case (op)
        `OP_STORE_CODES: access_span(op, addr, first, count);
        default: count = 0;
    endcase
    for (int i = 0; i < count; i++) begin
        model_bytes[word_base(addr) + first + i] = data[8*i +: 8];
    end
endfunction

// addressed bytes, then sign extension for lb, lh and lw
function automatic xlen_t load_from_model(input op_code_t op, input xlen_t addr);
    xlen_t       raw;
    int unsigned first;
    int unsigned count;
    raw = '0;
    access_span(op, addr, first, count);
    for (int i = 0; i < count; i++) begin
        raw[8*i +: 8] = model_bytes[word_base(addr) + first + i];
    end
    case (op)
        `OP_LB, `OP_LH, `OP_LW: begin
            if (count != 0 && raw[8*count-1]) begin
                raw |= ~64'd0 << (8*count);
            end
        end
        default: ;
    endcase
    return raw;
endfunction

// register writers by opcode class
function automatic logic writes_register(input op_code_t op);
    case (op)
        `OP_LOAD_CODES, `OP_ALU_CODES, `OP_JAL, `OP_JALR, `OP_CSR_A, `OP_CSR_B: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// write-back value, zero for codes that write nothing
function automatic xlen_t writeback_value(input op_code_t op, input xlen_t pc,
                                          input xlen_t alu, input xlen_t src2);
    case (op)
        `OP_LOAD_CODES:       return load_from_model(op, alu);
        `OP_ALU_CODES:        return alu;
        `OP_JAL, `OP_JALR:    return pc + 64'd4;
        `OP_CSR_A, `OP_CSR_B: return src2;
        default:              return '0;
    endcase
endfunction

`endif

// ==== verif/mem_subsys_tb.sv ====
`timescale 1ns/10ps

`include "mem_stage_params.svh"

module mem_subsys_tb import mem_stage_pkg::*; ();

    // instruction counts per section
    // watchdog sized from their total
    localparam int N_RESET     = 5;
    localparam int N_SELECT    = 13;
    localparam int N_REGION    = 16;
    localparam int N_RANDOM    = 40;
    localparam int N_ISSUE     = N_RESET + N_SELECT + N_REGION + 3 * N_RANDOM + 6 + 3 + 3;
    localparam int WATCHDOG_NS = (N_ISSUE + 50) * 20;

    logic     clk = 1'b0;
    logic     rst;
    logic     valid_ex_mem;
    xlen_t    pc_ex_mem;
    inst_t    inst_ex_mem;
    op_code_t opcode_ex_mem;
    xlen_t    alu_result_ex_mem;
    xlen_t    src2_ex_mem;
    logic     valid_mem_wb;
    xlen_t    pc_mem_wb;
    inst_t    inst_mem_wb;
    logic     reg_wr_en;
    reg_idx_t reg_wr_idx;
    xlen_t    reg_wr_value;

    integer seed = 32'hfe49;
    int     error_count = 0;
    int     issued = 0;
    xlen_t  region_base;

    // set while the capture edge still has rst high
    logic     reset_capture = 1'b0;

    // expected outputs
    // stage 1 set at the drive edge and stage 2 one edge later
    logic     exp1_live = 1'b0, exp2_live = 1'b0;
    logic     exp1_valid, exp2_valid;
    xlen_t    exp1_pc, exp2_pc;
    inst_t    exp1_inst, exp2_inst;
    logic     exp1_wr_en, exp2_wr_en;
    reg_idx_t exp1_idx, exp2_idx;
    xlen_t    exp1_value, exp2_value;

    // write-back selection mix
    // last two codes are unlisted
    op_code_t select_ops [N_SELECT] = '{24'h4000, 24'h100, 24'h200, 24'd19, 24'd24, 24'd47,
        24'h29000, `OP_JAL, `OP_JALR, `OP_CSR_A, `OP_CSR_B, 24'd0, 24'h123456};
    op_code_t store_ops [4] = '{`OP_SB, `OP_SH, `OP_SW, `OP_SD};
    op_code_t load_ops [7] = '{`OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_LWU, `OP_LD};

    `include "mem_model.svh"

    always #10 clk = ~clk;

    mem_subsys_top u_mem_subsys_top (
        .clk               (clk),
        .rst               (rst),
        .valid_ex_mem      (valid_ex_mem),
        .pc_ex_mem         (pc_ex_mem),
        .inst_ex_mem       (inst_ex_mem),
        .opcode_ex_mem     (opcode_ex_mem),
        .alu_result_ex_mem (alu_result_ex_mem),
        .src2_ex_mem       (src2_ex_mem),
        .valid_mem_wb      (valid_mem_wb),
        .pc_mem_wb         (pc_mem_wb),
        .inst_mem_wb       (inst_mem_wb),
        .reg_wr_en         (reg_wr_en),
        .reg_wr_idx        (reg_wr_idx),
        .reg_wr_value      (reg_wr_value)
    );

    // ************************************************************************
    // helpers
    // ************************************************************************

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic xlen_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // byte address inside the filled region
    function automatic xlen_t region_addr(input int unsigned word, input logic [2:0] off);
        return region_base + xlen_t'(word) * 8 + xlen_t'(off);
    endfunction

    task automatic value_error(input string what, input xlen_t got, input xlen_t want);
        error_count++;
        $display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
    endtask

    // one instruction per edge
    // model updated in program order
    task automatic issue(input logic valid, input op_code_t op, input xlen_t pc,
                         input inst_t inst, input xlen_t alu, input xlen_t src2);
        logic  live;
        logic  wr;
        xlen_t value;
        @(posedge clk);
        live  = valid && !reset_capture;
        wr    = live && writes_register(op);
        value = wr ? writeback_value(op, pc, alu, src2) : '0;
        if (live) begin
            store_to_model(op, alu, src2);
        end
        valid_ex_mem      <= valid;
        pc_ex_mem         <= pc;
        inst_ex_mem       <= inst;
        opcode_ex_mem     <= op;
        alu_result_ex_mem <= alu;
        src2_ex_mem       <= src2;
        exp1_live         <= 1'b1;
        exp1_valid        <= live;
        exp1_pc           <= pc;
        exp1_inst         <= inst;
        exp1_wr_en        <= wr;
        exp1_idx          <= live ? inst[11:7] : '0;
        exp1_value        <= value;
        issued++;
    endtask

    always @(posedge clk) begin
        exp2_live  <= exp1_live;
        exp2_valid <= exp1_valid;
        exp2_pc    <= exp1_pc;
        exp2_inst  <= exp1_inst;
        exp2_wr_en <= exp1_wr_en;
        exp2_idx   <= exp1_idx;
        exp2_value <= exp1_value;
    end

    // ************************************************************************
    // output checks one cycle after capture
    // ************************************************************************

    a_valid: assert property (@(posedge clk) exp2_live |-> (valid_mem_wb === exp2_valid))
        else value_error("valid_mem_wb", $sampled(valid_mem_wb), $sampled(exp2_valid));
    a_pc: assert property (@(posedge clk) (exp2_live && exp2_valid) |-> (pc_mem_wb === exp2_pc))
        else value_error("pc_mem_wb", $sampled(pc_mem_wb), $sampled(exp2_pc));
    a_inst: assert property (@(posedge clk)
        (exp2_live && exp2_valid) |-> (inst_mem_wb === exp2_inst))
        else value_error("inst_mem_wb", $sampled(inst_mem_wb), $sampled(exp2_inst));
    a_wr_en: assert property (@(posedge clk) exp2_live |-> (reg_wr_en === exp2_wr_en))
        else value_error("reg_wr_en", $sampled(reg_wr_en), $sampled(exp2_wr_en));
    a_idx: assert property (@(posedge clk) exp2_live |-> (reg_wr_idx === exp2_idx))
        else value_error("reg_wr_idx", $sampled(reg_wr_idx), $sampled(exp2_idx));
    a_value: assert property (@(posedge clk) exp2_live |-> (reg_wr_value === exp2_value))
        else value_error("reg_wr_value", $sampled(reg_wr_value), $sampled(exp2_value));

    // ************************************************************************
    // stimulus
    // ************************************************************************

    initial begin
        int unsigned word;
        xlen_t       addr;

        rst               = 1'b1;
        valid_ex_mem      = 1'b0;
        pc_ex_mem         = '0;
        inst_ex_mem       = '0;
        opcode_ex_mem     = '0;
        alu_result_ex_mem = '0;
        src2_ex_mem       = '0;

        // valid register writers captured under reset
        // outputs must stay low into the first cycle after reset
        reset_capture = 1'b1;
        for (int i = 0; i < N_RESET - 1; i++) begin
            issue(1'b1, 24'h4000, rand_word(), $random(seed), rand_word(), rand_word());
        end
        reset_capture = 1'b0;

        // last reset edge, captured after release
        issue(1'b0, '0, '0, '0, '0, '0);
        rst <= 1'b0;

        // write-back selection and pass-through
        for (int i = 0; i < N_SELECT; i++) begin
            issue(1'b1, select_ops[i], rand_word(), $random(seed), rand_word(), rand_word());
        end

        // fill a region so every later load reads defined bytes
        region_base = xlen_t'(pick(`MEM_WORDS - N_REGION)) * 8;
        for (int w = 0; w < N_REGION; w++) begin
            issue(1'b1, `OP_SD, rand_word(), $random(seed), region_addr(w, 3'd0), rand_word());
        end

        // random store with a load of the same word right behind it
        // then a load anywhere in the region
        for (int i = 0; i < N_RANDOM; i++) begin
            word = pick(N_REGION);
            addr = region_addr(word, 3'(pick(8)));
            issue(1'b1, store_ops[pick(4)], rand_word(), $random(seed), addr, rand_word());
            addr = region_addr(word, 3'(pick(8)));
            issue(1'b1, load_ops[pick(7)], rand_word(), $random(seed), addr, rand_word());
            addr = region_addr(pick(N_REGION), 3'(pick(8)));
            issue(1'b1, load_ops[pick(7)], rand_word(), $random(seed), addr, rand_word());
        end

        // lane isolation
        // sh at lane 7 must leave the word alone
        addr = region_addr(pick(N_REGION), 3'd0);
        issue(1'b1, `OP_SD, rand_word(), $random(seed), addr, rand_word());
        issue(1'b1, `OP_SB, rand_word(), $random(seed), addr + 3, rand_word());
        issue(1'b1, `OP_SH, rand_word(), $random(seed), addr + 5, rand_word());
        issue(1'b1, `OP_SH, rand_word(), $random(seed), addr + 7, rand_word());
        issue(1'b1, `OP_LD, rand_word(), $random(seed), addr, rand_word());
        issue(1'b1, `OP_LHU, rand_word(), $random(seed), addr + 5, rand_word());

        // bubbles with a store and an ALU code
        // then read the word back
        addr = region_addr(pick(N_REGION), 3'd0);
        issue(1'b0, `OP_SD, rand_word(), $random(seed), addr, rand_word());
        issue(1'b0, 24'h4000, rand_word(), $random(seed), rand_word(), rand_word());
        issue(1'b1, `OP_LD, rand_word(), $random(seed), addr, rand_word());

        // drain the last checks
        for (int i = 0; i < 3; i++) begin
            issue(1'b0, '0, '0, '0, '0, '0);
        end
        @(posedge clk);
        #1;

        $display("summary: %0d instructions issued, %0d mismatches", issued, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #WATCHDOG_NS;
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule : mem_subsys_tb
